/* tlb_pkg.sv */
// TLB region shared definitions
package tlb_pkg;

    // ------------------------------------------------------------------
    // Address geometry
    // ------------------------------------------------------------------
    localparam int VADDR_BITS  = 32;
    localparam int PADDR_BITS  = 32;
    localparam int PG_BITS     = 12;
    localparam int TLB_ORDER   = 4;
    localparam int TLB_ENTRIES = 1 << TLB_ORDER;
    localparam int TAG_BITS    = VADDR_BITS - PG_BITS - TLB_ORDER;
    localparam int PPN_BITS    = PADDR_BITS - PG_BITS;
    localparam int LEN_BITS    = 16;

    // Host bus
    localparam int WB_ADDR_BITS = 8;
    localparam int WB_DATA_BITS = 32;

    // ------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------
    localparam logic [WB_ADDR_BITS-1:0] REG_ENTRY_HI  = 8'h00;
    localparam logic [WB_ADDR_BITS-1:0] REG_ENTRY_LO  = 8'h04;
    localparam logic [WB_ADDR_BITS-1:0] REG_COMMIT    = 8'h08;
    localparam logic [WB_ADDR_BITS-1:0] REG_CTRL      = 8'h0C;
    localparam logic [WB_ADDR_BITS-1:0] REG_PF_VADDR  = 8'h10;
    localparam logic [WB_ADDR_BITS-1:0] REG_PF_STATUS = 8'h14;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                valid;
        logic                writable;
        logic [TAG_BITS-1:0] tag;
        logic [PPN_BITS-1:0] ppn;
    } tlb_entry_t;

    typedef struct packed {
        logic [VADDR_BITS-1:0] vaddr;
        logic [LEN_BITS-1:0]   len;
    } tlb_req_t;

    typedef struct packed {
        logic [PADDR_BITS-1:0] paddr;
        logic [LEN_BITS-1:0]   len;
    } dma_req_t;

    // Staged halves, each one full host word
    typedef struct packed {
        logic                                valid;
        logic [TAG_BITS-1:0]                 tag;
        logic [WB_DATA_BITS-TAG_BITS-2:0]    padding;
    } entry_hi_t;

    typedef struct packed {
        logic                                writable;
        logic [PPN_BITS-1:0]                 ppn;
        logic [WB_DATA_BITS-PPN_BITS-2:0]    padding;
    } entry_lo_t;

    typedef union packed {
        entry_hi_t hi;
        entry_lo_t lo;
    } tlb_stage_u;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [WB_ADDR_BITS-1:0] adr;
        logic [WB_DATA_BITS-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                    ack;
        logic [WB_DATA_BITS-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [VADDR_BITS-1:0] vaddr;
        logic                  wr;
    } pf_info_t;

endpackage

/* tlb_table.sv */
// Direct-mapped TLB storage
`timescale 1ns/100ps

module tlb_table (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          wr_en,
    input  logic [tlb_pkg::TLB_ORDER-1:0] wr_idx,
    input  tlb_pkg::tlb_entry_t           wr_entry,
    input  logic [tlb_pkg::TLB_ORDER-1:0] rd_idx,
    output tlb_pkg::tlb_entry_t           rd_entry
);
    import tlb_pkg::*;

    // Valid bits are kept apart so they can be cleared on reset
    logic [TLB_ENTRIES-1:0] valid_q;
    logic                   wrt_q [TLB_ENTRIES];
    logic [TAG_BITS-1:0]    tag_q [TLB_ENTRIES];
    logic [PPN_BITS-1:0]    ppn_q [TLB_ENTRIES];

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= wr_entry.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            wrt_q[wr_idx] <= wr_entry.writable;
            tag_q[wr_idx] <= wr_entry.tag;
            ppn_q[wr_idx] <= wr_entry.ppn;
        end
    end

    // ------------------------------------------------------------------
    // Registered read port, old data on a same-index collision
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        rd_entry.valid    <= valid_q[rd_idx];
        rd_entry.writable <= wrt_q[rd_idx];
        rd_entry.tag      <= tag_q[rd_idx];
        rd_entry.ppn      <= ppn_q[rd_idx];
    end

endmodule

/* tlb_cnfg_slave.sv */
// TLB configuration register slave
`timescale 1ns/100ps

module tlb_cnfg_slave (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  tlb_pkg::wb_req_t              wb_req,
    output tlb_pkg::wb_rsp_t              wb_rsp,
    output logic                          tbl_wr_en,
    output logic [tlb_pkg::TLB_ORDER-1:0] tbl_wr_idx,
    output tlb_pkg::tlb_entry_t           tbl_wr_entry,
    input  logic                          pf_report,
    input  tlb_pkg::pf_info_t             pf_info,
    output logic                          pf_clear,
    output logic                          decouple,
    output logic                          pf_irq
);
    import tlb_pkg::*;

    logic                    ack_q;
    logic                    served_q;
    logic [WB_DATA_BITS-1:0] rdata_q;
    logic                    access;
    logic                    wr_fire;
    tlb_stage_u              wdata;
    entry_hi_t               hi_q;
    entry_lo_t               lo_q;
    logic                    decouple_q;
    logic                    pf_pending_q;
    logic                    pf_clear_q;
    pf_info_t                pf_q;

    // ------------------------------------------------------------------
    // Bus handshake
    // ------------------------------------------------------------------
    // One ack per strobe, held off until stb drops
    assign access  = wb_req.cyc && wb_req.stb && !ack_q && !served_q;
    assign wr_fire = access && wb_req.we;
    assign wdata   = wb_req.dat;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ack_q    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (!(wb_req.cyc && wb_req.stb)) begin
                served_q <= 1'b0;
            end else if (ack_q) begin
                served_q <= 1'b1;
            end
        end
    end

    // Read data lands together with ack
    always_ff @(posedge aclk) begin
        if (access) begin
            case (wb_req.adr)
                REG_ENTRY_HI:  rdata_q <= hi_q;
                REG_ENTRY_LO:  rdata_q <= lo_q;
                REG_CTRL:      rdata_q <= {{(WB_DATA_BITS-1){1'b0}}, decouple_q};
                REG_PF_VADDR:  rdata_q <= pf_q.vaddr;
                REG_PF_STATUS: rdata_q <= {{(WB_DATA_BITS-2){1'b0}}, pf_q.wr, pf_pending_q};
                default:       rdata_q <= '0;
            endcase
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rdata_q};

    // ------------------------------------------------------------------
    // Entry staging and commit
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (wr_fire && wb_req.adr == REG_ENTRY_HI) begin
            hi_q <= wdata.hi;
        end
        if (wr_fire && wb_req.adr == REG_ENTRY_LO) begin
            lo_q <= wdata.lo;
        end
        // Fault details from whichever engine holds the lock
        if (pf_report) begin
            pf_q <= pf_info;
        end
    end

    assign tbl_wr_en    = wr_fire && wb_req.adr == REG_COMMIT;
    assign tbl_wr_idx   = wb_req.dat[TLB_ORDER-1:0];
    assign tbl_wr_entry = '{valid: hi_q.valid, writable: lo_q.writable,
                            tag: hi_q.tag, ppn: lo_q.ppn};

    // ------------------------------------------------------------------
    // Control and page fault state
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            decouple_q   <= 1'b0;
            pf_pending_q <= 1'b0;
            pf_clear_q   <= 1'b0;
        end else begin
            pf_clear_q <= 1'b0;
            if (wr_fire && wb_req.adr == REG_CTRL) begin
                decouple_q <= wb_req.dat[0];
            end
            if (wr_fire && wb_req.adr == REG_PF_STATUS) begin
                pf_pending_q <= 1'b0;
                pf_clear_q   <= 1'b1;
            end else if (pf_report) begin
                pf_pending_q <= 1'b1;
            end
        end
    end

    assign decouple = decouple_q;
    assign pf_clear = pf_clear_q;
    assign pf_irq   = pf_pending_q;

endmodule

/* tlb_lock.sv */
// TLB read port lock
`timescale 1ns/100ps

module tlb_lock (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          rd_lock,
    input  logic                          wr_lock,
    input  logic                          rd_unlock,
    input  logic                          wr_unlock,
    output logic                          rd_grant,
    output logic                          wr_grant,
    input  logic [tlb_pkg::TLB_ORDER-1:0] rd_idx,
    input  logic [tlb_pkg::TLB_ORDER-1:0] wr_idx,
    output logic [tlb_pkg::TLB_ORDER-1:0] tbl_idx
);

    typedef enum logic [1:0] {
        LK_FREE,
        LK_RD,
        LK_WR
    } lock_t;

    lock_t state_q;

    // Read side wins when both ask in the same cycle
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= LK_FREE;
        end else begin
            case (state_q)
                LK_FREE: begin
                    if (rd_lock) begin
                        state_q <= LK_RD;
                    end else if (wr_lock) begin
                        state_q <= LK_WR;
                    end
                end
                LK_RD:   if (rd_unlock) state_q <= LK_FREE;
                LK_WR:   if (wr_unlock) state_q <= LK_FREE;
                default: state_q <= LK_FREE;
            endcase
        end
    end

    assign rd_grant = state_q == LK_RD;
    assign wr_grant = state_q == LK_WR;

    // Holder drives the table index
    assign tbl_idx = (state_q == LK_WR) ? wr_idx : rd_idx;

endmodule

/* tlb_fsm.sv */
// TLB translation engine
`timescale 1ns/100ps

module tlb_fsm #(
    parameter bit IS_WR = 1'b0
) (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  tlb_pkg::tlb_req_t             req,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic                          decouple,
    output logic                          lock,
    output logic                          unlock,
    input  logic                          grant,
    output logic [tlb_pkg::TLB_ORDER-1:0] lookup_idx,
    input  tlb_pkg::tlb_entry_t           entry,
    output logic                          pf_report,
    output tlb_pkg::pf_info_t             pf_info,
    input  logic                          pf_clear,
    output tlb_pkg::dma_req_t             dma,
    output logic                          dma_valid,
    input  logic                          dma_ready
);
    import tlb_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOCK,
        ST_CMP,
        ST_FAULT,
        ST_SEND
    } state_t;

    state_t                state_q;
    logic [VADDR_BITS-1:0] addr_q;
    logic [LEN_BITS-1:0]   rem_q;
    dma_req_t              dma_q;
    logic [PG_BITS:0]      pg_rem;
    logic [LEN_BITS-1:0]   chunk_len;
    logic                  last;
    logic                  hit;
    logic                  xfer;

    // ------------------------------------------------------------------
    // Chunk and lookup
    // ------------------------------------------------------------------
    // Bytes left to the end of the current page
    assign pg_rem    = {1'b1, {PG_BITS{1'b0}}} - {1'b0, addr_q[PG_BITS-1:0]};
    assign chunk_len = (rem_q <= LEN_BITS'(pg_rem)) ? rem_q : LEN_BITS'(pg_rem);
    assign last      = rem_q == chunk_len;

    assign lookup_idx = addr_q[PG_BITS +: TLB_ORDER];
    assign hit = entry.valid && (entry.tag == addr_q[VADDR_BITS-1 -: TAG_BITS]) &&
                 (!IS_WR || entry.writable);

    assign xfer = (state_q == ST_SEND) && dma_ready;

    // ------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:  if (req_valid && req_ready) state_q <= ST_LOCK;
                ST_LOCK:  if (grant) state_q <= ST_CMP;
                ST_CMP:   state_q <= hit ? ST_SEND : ST_FAULT;
                // Lock stays held, the retry reads the same index
                ST_FAULT: if (pf_clear) state_q <= ST_CMP;
                ST_SEND: begin
                    if (dma_ready) begin
                        state_q <= last ? ST_IDLE : ST_LOCK;
                    end
                end
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (state_q == ST_IDLE && req_valid && req_ready) begin
            addr_q <= req.vaddr;
            rem_q  <= (req.len == '0) ? LEN_BITS'(1) : req.len;
        end else if (xfer) begin
            addr_q <= addr_q + VADDR_BITS'(chunk_len);
            rem_q  <= rem_q - chunk_len;
        end

        if (state_q == ST_CMP && hit) begin
            dma_q.paddr <= {entry.ppn, addr_q[PG_BITS-1:0]};
            dma_q.len   <= chunk_len;
        end
    end

    // No request is taken while reset is applied
    assign req_ready = aresetn && (state_q == ST_IDLE) && !decouple;
    assign lock      = state_q == ST_LOCK;
    assign unlock    = xfer;
    assign pf_report = (state_q == ST_CMP) && !hit;
    assign pf_info   = '{vaddr: addr_q, wr: IS_WR};
    assign dma       = dma_q;
    assign dma_valid = state_q == ST_SEND;

endmodule

/* tlb_region_top.sv */
// TLB region top level
`timescale 1ns/100ps

module tlb_region_top (
    input  logic                aclk,
    input  logic                aresetn,
    input  tlb_pkg::wb_req_t    wb_req,
    output tlb_pkg::wb_rsp_t    wb_rsp,
    input  tlb_pkg::tlb_req_t   rd_req,
    input  logic                rd_req_valid,
    output logic                rd_req_ready,
    input  tlb_pkg::tlb_req_t   wr_req,
    input  logic                wr_req_valid,
    output logic                wr_req_ready,
    output tlb_pkg::dma_req_t   rd_dma,
    output logic                rd_dma_valid,
    input  logic                rd_dma_ready,
    output tlb_pkg::dma_req_t   wr_dma,
    output logic                wr_dma_valid,
    input  logic                wr_dma_ready,
    output logic                decouple,
    output logic                pf_irq
);
    import tlb_pkg::*;

    logic                 tbl_wr_en;
    logic [TLB_ORDER-1:0] tbl_wr_idx;
    tlb_entry_t           tbl_wr_entry;
    logic [TLB_ORDER-1:0] tbl_rd_idx;
    tlb_entry_t           tbl_rd_entry;
    logic                 rd_lock, wr_lock, rd_unlock, wr_unlock;
    logic                 rd_grant, wr_grant;
    logic [TLB_ORDER-1:0] rd_idx, wr_idx;
    logic                 rd_pf_report, wr_pf_report, pf_report, pf_clear;
    pf_info_t             rd_pf_info, wr_pf_info, pf_info;

    // Only the lock holder can fault
    assign pf_report = rd_pf_report || wr_pf_report;
    assign pf_info   = rd_pf_report ? rd_pf_info : wr_pf_info;

    // ------------------------------------------------------------------
    // Config slave, table and lock
    // ------------------------------------------------------------------
    tlb_cnfg_slave inst_cnfg_slave (
        .aclk(aclk), .aresetn(aresetn),
        .wb_req(wb_req), .wb_rsp(wb_rsp),
        .tbl_wr_en(tbl_wr_en), .tbl_wr_idx(tbl_wr_idx), .tbl_wr_entry(tbl_wr_entry),
        .pf_report(pf_report), .pf_info(pf_info), .pf_clear(pf_clear),
        .decouple(decouple), .pf_irq(pf_irq)
    );

    tlb_table inst_table (
        .aclk(aclk), .aresetn(aresetn),
        .wr_en(tbl_wr_en), .wr_idx(tbl_wr_idx), .wr_entry(tbl_wr_entry),
        .rd_idx(tbl_rd_idx), .rd_entry(tbl_rd_entry)
    );

    tlb_lock inst_lock (
        .aclk(aclk), .aresetn(aresetn),
        .rd_lock(rd_lock), .wr_lock(wr_lock),
        .rd_unlock(rd_unlock), .wr_unlock(wr_unlock),
        .rd_grant(rd_grant), .wr_grant(wr_grant),
        .rd_idx(rd_idx), .wr_idx(wr_idx), .tbl_idx(tbl_rd_idx)
    );

    // ------------------------------------------------------------------
    // Translation engines
    // ------------------------------------------------------------------
    tlb_fsm #(.IS_WR(1'b0)) inst_fsm_rd (
        .aclk(aclk), .aresetn(aresetn),
        .req(rd_req), .req_valid(rd_req_valid), .req_ready(rd_req_ready),
        .decouple(decouple),
        .lock(rd_lock), .unlock(rd_unlock), .grant(rd_grant),
        .lookup_idx(rd_idx), .entry(tbl_rd_entry),
        .pf_report(rd_pf_report), .pf_info(rd_pf_info), .pf_clear(pf_clear),
        .dma(rd_dma), .dma_valid(rd_dma_valid), .dma_ready(rd_dma_ready)
    );

    tlb_fsm #(.IS_WR(1'b1)) inst_fsm_wr (
        .aclk(aclk), .aresetn(aresetn),
        .req(wr_req), .req_valid(wr_req_valid), .req_ready(wr_req_ready),
        .decouple(decouple),
        .lock(wr_lock), .unlock(wr_unlock), .grant(wr_grant),
        .lookup_idx(wr_idx), .entry(tbl_rd_entry),
        .pf_report(wr_pf_report), .pf_info(wr_pf_info), .pf_clear(pf_clear),
        .dma(wr_dma), .dma_valid(wr_dma_valid), .dma_ready(wr_dma_ready)
    );

endmodule

/* tb_tlb_region.sv */
// TLB region testbench
`timescale 1ns/100ps

module tb_tlb_region;
    import tlb_pkg::*;

    localparam int N_RAND = 12;
    // Random phase per path, one fault request, two on the write-protect page, one decouple
    localparam int N_REQS = 2 * N_RAND + 4;
    // Installs, unmapped fault, write-protect fault, control, staging readback
    localparam int N_WB   = 3 * 15 + 6 + 9 + 3 + 4;
    localparam int LIMIT  = 200 * N_REQS + 50 * N_WB;

    logic                aclk;
    logic                aresetn;
    wb_req_t             wb_req;
    wb_rsp_t             wb_rsp;
    tlb_req_t            rd_req;
    logic                rd_req_valid;
    logic                rd_req_ready;
    tlb_req_t            wr_req;
    logic                wr_req_valid;
    logic                wr_req_ready;
    dma_req_t            rd_dma;
    logic                rd_dma_valid;
    logic                rd_dma_ready;
    dma_req_t            wr_dma;
    logic                wr_dma_valid;
    logic                wr_dma_ready;
    logic                decouple;
    logic                pf_irq;

    integer              seed = 70;
    int                  cycles;
    int                  errors = 0;
    tlb_entry_t          model_tbl [TLB_ENTRIES];
    dma_req_t            exp_rd_q [$];
    dma_req_t            exp_wr_q [$];
    logic [31:0]         rd_bytes_req = '0;
    logic [31:0]         rd_bytes_seen = '0;
    logic [31:0]         wr_bytes_req = '0;
    logic [31:0]         wr_bytes_seen = '0;
    logic [TAG_BITS-1:0] tag_all;

    tlb_region_top uut (
        .aclk(aclk), .aresetn(aresetn),
        .wb_req(wb_req), .wb_rsp(wb_rsp),
        .rd_req(rd_req), .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
        .wr_req(wr_req), .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
        .rd_dma(rd_dma), .rd_dma_valid(rd_dma_valid), .rd_dma_ready(rd_dma_ready),
        .wr_dma(wr_dma), .wr_dma_valid(wr_dma_valid), .wr_dma_ready(wr_dma_ready),
        .decouple(decouple), .pf_irq(pf_irq)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic stop_run(input string msg);
        errors++;
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_dma(input string name, input dma_req_t got, input dma_req_t want);
        string msg;
        if (got !== want) begin
            msg = $sformatf("error %s: got paddr 0x%08h len 0x%04h",
                            name, got.paddr, got.len);
            msg = {msg, $sformatf(", expected paddr 0x%08h len 0x%04h",
                                  want.paddr, want.len)};
            stop_run(msg);
        end
    endtask

    task automatic check_wb(input string name, input logic [WB_DATA_BITS-1:0] got,
                            input logic [WB_DATA_BITS-1:0] want);
        if (got !== want) begin
            stop_run($sformatf("error %s: got 0x%08h, expected 0x%08h", name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            stop_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // ------------------------------------------------------------------
    // Bus and request drivers
    // ------------------------------------------------------------------
    task automatic wb_access(input logic we, input logic [WB_ADDR_BITS-1:0] adr,
                             input logic [WB_DATA_BITS-1:0] wdat,
                             output logic [WB_DATA_BITS-1:0] rdat);
        int waits;
        waits = 0;
        @(negedge aclk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        while (!wb_rsp.ack) begin
            @(negedge aclk);
            waits++;
        end
        check_wb("wb_ack_delay", 32'(waits), 32'd1);
        rdat = wb_rsp.dat;
        // Strobe stays up past the ack and must draw no second one
        repeat (2) begin
            @(negedge aclk);
            check_bit("wb_ack", wb_rsp.ack, 1'b0);
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_BITS-1:0] adr,
                            input logic [WB_DATA_BITS-1:0] wdat);
        logic [WB_DATA_BITS-1:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [WB_ADDR_BITS-1:0] adr,
                           output logic [WB_DATA_BITS-1:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic install_entry(input logic [TLB_ORDER-1:0] idx, input logic valid,
                                 input logic writable, input logic [TAG_BITS-1:0] tag,
                                 input logic [PPN_BITS-1:0] ppn);
        entry_hi_t hi;
        entry_lo_t lo;
        hi = '{valid: valid, tag: tag, padding: '0};
        lo = '{writable: writable, ppn: ppn, padding: '0};
        wb_write(REG_ENTRY_HI, hi);
        wb_write(REG_ENTRY_LO, lo);
        wb_write(REG_COMMIT, WB_DATA_BITS'(idx));
        model_tbl[idx] = '{valid: valid, writable: writable, tag: tag, ppn: ppn};
    endtask

    task automatic send_req(input bit is_wr, input tlb_req_t r);
        @(negedge aclk);
        if (is_wr) begin
            wr_req       = r;
            wr_req_valid = 1'b1;
        end else begin
            rd_req       = r;
            rd_req_valid = 1'b1;
        end
        while (!(is_wr ? wr_req_ready : rd_req_ready)) @(negedge aclk);
        @(negedge aclk);
        if (is_wr) begin
            wr_req_valid = 1'b0;
        end else begin
            rd_req_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_rd_q.size() != 0 || exp_wr_q.size() != 0) @(negedge aclk);
        repeat (2) @(negedge aclk);
    endtask

    task automatic wait_irq();
        while (!pf_irq) @(negedge aclk);
    endtask

    // ------------------------------------------------------------------
    // Translation model
    // ------------------------------------------------------------------
    // Page-bounded chunks, paddr from the model table
    task automatic expect_chunks(input bit is_wr, input tlb_req_t r);
        logic [31:0] addr;
        logic [31:0] rem;
        logic [31:0] pg_left;
        logic [31:0] clen;
        tlb_entry_t  e;
        dma_req_t    d;
        addr = r.vaddr;
        rem  = (r.len == '0) ? 32'd1 : 32'(r.len);
        if (is_wr) begin
            wr_bytes_req += rem;
        end else begin
            rd_bytes_req += rem;
        end
        while (rem != 0) begin
            pg_left = (32'd1 << PG_BITS) - 32'(addr[PG_BITS-1:0]);
            clen    = (rem < pg_left) ? rem : pg_left;
            e       = model_tbl[addr[PG_BITS +: TLB_ORDER]];
            d.paddr = {e.ppn, addr[PG_BITS-1:0]};
            d.len   = clen[LEN_BITS-1:0];
            if (is_wr) begin
                exp_wr_q.push_back(d);
            end else begin
                exp_rd_q.push_back(d);
            end
            addr += clen;
            rem  -= clen;
        end
    endtask

    // Mostly short requests, some up to two page crossings
    function automatic tlb_req_t make_req(input logic [TLB_ORDER-1:0] idx,
                                          input logic [31:0] rnd);
        tlb_req_t r;
        r.vaddr = {tag_all, idx, rnd[PG_BITS-1:0]};
        r.len   = rnd[31] ? LEN_BITS'(rnd[28:16]) : LEN_BITS'(rnd[21:16]);
        return r;
    endfunction

    // ------------------------------------------------------------------
    // DMA port monitors with random back-pressure
    // ------------------------------------------------------------------
    initial begin : rd_dma_watch
        dma_req_t want;
        logic [31:0] rnd;
        rd_dma_ready = 1'b0;
        forever begin
            @(negedge aclk);
            rnd = rand_word();
            rd_dma_ready = rnd[0];
            if (rd_dma_valid && rd_dma_ready) begin
                if (exp_rd_q.size() == 0) begin
                    stop_run("read port issued a DMA request that was not expected");
                end else begin
                    want = exp_rd_q.pop_front();
                    check_dma("rd_dma", rd_dma, want);
                    rd_bytes_seen += 32'(rd_dma.len);
                end
            end
        end
    end

    initial begin : wr_dma_watch
        dma_req_t want;
        logic [31:0] rnd;
        wr_dma_ready = 1'b0;
        forever begin
            @(negedge aclk);
            rnd = rand_word();
            wr_dma_ready = rnd[1];
            if (wr_dma_valid && wr_dma_ready) begin
                if (exp_wr_q.size() == 0) begin
                    stop_run("write port issued a DMA request that was not expected");
                end else begin
                    want = exp_wr_q.pop_front();
                    check_dma("wr_dma", wr_dma, want);
                    wr_bytes_seen += 32'(wr_dma.len);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin : main
        tlb_req_t             rd_list [N_RAND];
        tlb_req_t             wr_list [N_RAND];
        tlb_req_t             r;
        logic [31:0]          rnd;
        logic [31:0]          rdat;
        logic [31:0]          hi_w;
        logic [31:0]          lo_w;
        logic [TLB_ORDER-1:0] idx;

        aresetn      = 1'b0;
        wb_req       = '0;
        rd_req       = '0;
        rd_req_valid = 1'b0;
        wr_req       = '0;
        wr_req_valid = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            model_tbl[i] = '0;
        end
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        check_bit("wb_ack", wb_rsp.ack, 1'b0);
        check_bit("pf_irq", pf_irq, 1'b0);
        check_bit("decouple", decouple, 1'b0);
        check_bit("rd_dma_valid", rd_dma_valid, 1'b0);
        check_bit("wr_dma_valid", wr_dma_valid, 1'b0);
        check_bit("rd_req_ready", rd_req_ready, 1'b0);
        check_bit("wr_req_ready", wr_req_ready, 1'b0);
        aresetn = 1'b1;

        // One shared tag keeps neighbouring pages mapped
        rnd = rand_word();
        tag_all = rnd[TAG_BITS-1:0];
        for (int i = 0; i < 15; i++) begin
            rnd = rand_word();
            install_entry(TLB_ORDER'(i), 1'b1, 1'b1, tag_all, rnd[PPN_BITS-1:0]);
        end

        // Random traffic on both paths
        for (int i = 0; i < N_RAND; i++) begin
            rnd = rand_word();
            idx = TLB_ORDER'(rnd[7:0] % 8'd13);
            rd_list[i] = make_req(idx, rand_word());
            rnd = rand_word();
            idx = TLB_ORDER'(rnd[7:0] % 8'd13);
            wr_list[i] = make_req(idx, rand_word());
            if (i == 0) begin
                rd_list[i].len = '0;
                wr_list[i].len = '0;
            end
            expect_chunks(1'b0, rd_list[i]);
            expect_chunks(1'b1, wr_list[i]);
        end
        fork
            begin
                for (int i = 0; i < N_RAND; i++) send_req(1'b0, rd_list[i]);
            end
            begin
                for (int i = 0; i < N_RAND; i++) send_req(1'b1, wr_list[i]);
            end
        join
        wait_drain();

        // Unmapped page on the read path
        rnd = rand_word();
        r.vaddr = {tag_all, TLB_ORDER'(15), 1'b0, rnd[10:0]};
        r.len   = LEN_BITS'(rnd[25:16]);
        send_req(1'b0, r);
        wait_irq();
        wb_read(REG_PF_VADDR, rdat);
        check_wb("pf_vaddr", rdat, r.vaddr);
        wb_read(REG_PF_STATUS, rdat);
        check_wb("pf_status", rdat, 32'h1);
        rnd = rand_word();
        install_entry(TLB_ORDER'(15), 1'b1, 1'b1, tag_all, rnd[PPN_BITS-1:0]);
        expect_chunks(1'b0, r);
        wb_write(REG_PF_STATUS, '0);
        check_bit("pf_irq", pf_irq, 1'b0);
        wait_drain();

        // Read-only page, read passes and write faults
        rnd = rand_word();
        install_entry(TLB_ORDER'(14), 1'b1, 1'b0, tag_all, rnd[PPN_BITS-1:0]);
        rnd = rand_word();
        r.vaddr = {tag_all, TLB_ORDER'(14), 1'b0, rnd[10:0]};
        r.len   = LEN_BITS'(rnd[25:16]);
        expect_chunks(1'b0, r);
        send_req(1'b0, r);
        wait_drain();
        check_bit("pf_irq", pf_irq, 1'b0);
        send_req(1'b1, r);
        wait_irq();
        wb_read(REG_PF_VADDR, rdat);
        check_wb("pf_vaddr", rdat, r.vaddr);
        wb_read(REG_PF_STATUS, rdat);
        check_wb("pf_status", rdat, 32'h3);
        install_entry(TLB_ORDER'(14), 1'b1, 1'b1, tag_all, model_tbl[14].ppn);
        expect_chunks(1'b1, r);
        wb_write(REG_PF_STATUS, '0);
        check_bit("pf_irq", pf_irq, 1'b0);
        wait_drain();

        // Decouple blocks request acceptance
        wb_write(REG_CTRL, 32'h1);
        check_bit("decouple", decouple, 1'b1);
        repeat (4) begin
            @(negedge aclk);
            check_bit("rd_req_ready", rd_req_ready, 1'b0);
            check_bit("wr_req_ready", wr_req_ready, 1'b0);
        end
        wb_read(REG_CTRL, rdat);
        check_wb("ctrl", rdat, 32'h1);
        wb_write(REG_CTRL, 32'h0);
        check_bit("decouple", decouple, 1'b0);
        check_bit("rd_req_ready", rd_req_ready, 1'b1);
        check_bit("wr_req_ready", wr_req_ready, 1'b1);
        rnd = rand_word();
        idx = TLB_ORDER'(rnd[7:0] % 8'd13);
        r = make_req(idx, rand_word());
        expect_chunks(1'b1, r);
        send_req(1'b1, r);
        wait_drain();

        // Staging word readback
        hi_w = rand_word();
        lo_w = rand_word();
        wb_write(REG_ENTRY_HI, hi_w);
        wb_write(REG_ENTRY_LO, lo_w);
        wb_read(REG_ENTRY_HI, rdat);
        check_wb("entry_hi", rdat, hi_w);
        wb_read(REG_ENTRY_LO, rdat);
        check_wb("entry_lo", rdat, lo_w);

        // Chunk lengths must add up to the requested bytes
        check_wb("rd_bytes", rd_bytes_seen, rd_bytes_req);
        check_wb("wr_bytes", wr_bytes_seen, wr_bytes_req);

        if (errors == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

/* filelist.f */
tlb_pkg.sv
tlb_table.sv
tlb_cnfg_slave.sv
tlb_lock.sv
tlb_fsm.sv
tlb_region_top.sv
tb_tlb_region.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_tlb_region
FILELIST  := filelist.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)
